// ==== src/aes_dec_pkg.sv ====
////////////////////
// AES-128 decryption core shared types
// block sizes, state operations and the S-box and rcon tables
////////////////////

`default_nettype none

package aes_dec_pkg;

	localparam int NUM_ROUNDS = 10;
	localparam int NUM_COLS = 4;

	typedef logic [127:0] aes_block_t;
	typedef logic [31:0] aes_word_t;
	typedef logic [7:0] aes_byte_t;
	typedef logic [3:0] aes_round_t;
	typedef logic [1:0] aes_col_t;

	// what the state register loads in a cycle
	typedef enum logic [2:0] {
		op_hold,
		op_add_key,
		op_inv_shift,
		op_inv_sub,
		op_inv_mix
	} aes_op_t;

	// one table row of 16 bytes per literal, entry 0 is the leftmost byte
	localparam logic [0:255][7:0] SBOX_TBL = {
		128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
	};

	localparam logic [0:255][7:0] INV_SBOX_TBL = {
		128'h52096ad53036a538bf40a39e81f3d7fb, 128'h7ce339829b2fff87348e4344c4dee9cb,
		128'h547b9432a6c2233dee4c950b42fac34e, 128'h082ea16628d924b2765ba2496d8bd125,
		128'h72f8f66486689816d4a45ccc5d65b692, 128'h6c704850fdedb9da5e154657a78d9d84,
		128'h90d8ab008cbcd30af7e45805b8b34506, 128'hd02c1e8fca3f0f02c1afbd0301138a6b,
		128'h3a9111414f67dcea97f2cfcef0b4e673, 128'h96ac7422e7ad3585e2f937e81c75df6e,
		128'h47f11a711d29c5896fb7620eaa18be1b, 128'hfc563e4bc6d279209adbc0fe78cd5af4,
		128'h1fdda8338807c731b11210592780ec5f, 128'h60517fa919b54a0d2de57a9f93c99cef,
		128'ha0e03b4dae2af5b0c8ebbb3c83539961, 128'h172b047eba77d626e169146355210c7d
	};

	// round constants, entry 0 unused
	localparam logic [0:10][7:0] RCON_TBL = {
		8'h00, 8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
		8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
	};

	function automatic aes_byte_t sbox(input aes_byte_t b);
		return SBOX_TBL[b];
	endfunction

	function automatic aes_byte_t inv_sbox(input aes_byte_t b);
		return INV_SBOX_TBL[b];
	endfunction

	function automatic aes_byte_t rcon(input aes_round_t r);
		return (r <= NUM_ROUNDS) ? RCON_TBL[r] : 8'h00;
	endfunction

endpackage

`default_nettype wire

// ==== src/aes_dec_ctrl.sv ====
////////////////////
// AES decryption control FSM
// sequences key expansion, the inverse rounds and done
////////////////////

`timescale 1ns/1ps
`default_nettype none

module aes_dec_ctrl
	import aes_dec_pkg::*;
(
	input  logic       CLK,
	input  logic       RESET,
	input  logic       start,
	output logic       done,
	output logic       load,
	output logic       key_step,
	output aes_round_t round,
	output aes_op_t    op,
	output logic       mix_en,
	output aes_col_t   col
);

	typedef enum logic [3:0] {
		ph_idle,
		ph_key,
		ph_add_first,
		ph_shift,
		ph_sub,
		ph_add,
		ph_mix,
		ph_mix_load,
		ph_done
	} phase_t;

	phase_t phase;

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			phase <= ph_idle;
			round <= '0;
			col <= '0;
			done <= 1'b0;
		end
		else
		begin
			// one cycle behind the done phase
			done <= (phase == ph_done);
			case (phase)
			ph_idle:
				if (start)
				begin
					phase <= ph_key;
					round <= aes_round_t'(1);
				end
			// round counts up while the key schedule is built
			ph_key:
				if (round == aes_round_t'(NUM_ROUNDS))
					phase <= ph_add_first;
				else
					round <= round + 1'b1;
			ph_add_first:
			begin
				phase <= ph_shift;
				round <= round - 1'b1;
			end
			ph_shift:
				phase <= ph_sub;
			ph_sub:
				phase <= ph_add;
			// last round has no mix columns
			ph_add:
				if (round == '0)
					phase <= ph_done;
				else
				begin
					phase <= ph_mix;
					col <= '0;
				end
			ph_mix:
			begin
				col <= col + 1'b1;
				if (col == aes_col_t'(NUM_COLS - 1))
					phase <= ph_mix_load;
			end
			ph_mix_load:
			begin
				phase <= ph_shift;
				round <= round - 1'b1;
			end
			ph_done:
				if (!start)
					phase <= ph_idle;
			default:
				phase <= ph_idle;
			endcase
		end
	end

	always_comb
	begin
		load = (phase == ph_idle) && start;
		key_step = (phase == ph_key);
		mix_en = (phase == ph_mix);
		case (phase)
		ph_add_first, ph_add:
			op = op_add_key;
		ph_shift:
			op = op_inv_shift;
		ph_sub:
			op = op_inv_sub;
		ph_mix_load:
			op = op_inv_mix;
		default:
			op = op_hold;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/aes_key_expand.sv ====
////////////////////
// AES-128 key expansion
// builds one round key per cycle into an 11 entry store
////////////////////

`timescale 1ns/1ps
`default_nettype none

module aes_key_expand
	import aes_dec_pkg::*;
(
	input  logic       CLK,
	input  logic       RESET,
	input  logic       load,
	input  logic       key_step,
	input  aes_round_t round,
	input  aes_block_t key,
	output aes_block_t round_key
);

	aes_block_t keys [0:NUM_ROUNDS];
	aes_block_t prev_key;
	aes_word_t temp;
	aes_word_t nw0;
	aes_word_t nw1;
	aes_word_t nw2;
	aes_word_t nw3;

	always_comb
	begin
		prev_key = keys[round - 1'b1];
		// rot word, sub word, then rcon on the top byte
		temp = {sbox(prev_key[23:16]), sbox(prev_key[15:8]),
			sbox(prev_key[7:0]), sbox(prev_key[31:24])};
		temp = temp ^ {rcon(round), 24'h0};
		nw0 = prev_key[127:96] ^ temp;
		nw1 = prev_key[95:64] ^ nw0;
		nw2 = prev_key[63:32] ^ nw1;
		nw3 = prev_key[31:0] ^ nw2;
	end

	// no writes while in reset
	always_ff @(posedge CLK)
	begin
		if (!RESET)
		begin
			if (load)
				keys[0] <= key;
			else if (key_step)
				keys[round] <= {nw0, nw1, nw2, nw3};
		end
	end

	assign round_key = keys[round];

endmodule

`default_nettype wire

// ==== src/aes_inv_mix_col.sv ====
////////////////////
// column-serial inverse mix columns
// one column per cycle into a result register
////////////////////

`timescale 1ns/1ps
`default_nettype none

module aes_inv_mix_col
	import aes_dec_pkg::*;
(
	input  logic       CLK,
	input  logic       RESET,
	input  logic       mix_en,
	input  aes_col_t   col,
	input  aes_block_t state,
	output aes_block_t mix_out
);

	aes_word_t col_in;
	aes_word_t col_res;
	aes_block_t col_reg;

	// GF(2^8) multiply by a 4-bit constant
	function automatic aes_byte_t gf_mul(input aes_byte_t a, input logic [3:0] m);
		aes_byte_t p;
		aes_byte_t acc;
		acc = '0;
		p = a;
		for (int i = 0; i < 4; i++)
		begin
			if (m[i])
				acc = acc ^ p;
			p = {p[6:0], 1'b0} ^ (p[7] ? 8'h1b : 8'h00);
		end
		return acc;
	endfunction

	always_comb
	begin
		// column 0 sits in the top word
		col_in = state[(NUM_COLS - 1 - col) * 32 +: 32];
		col_res[31:24] = gf_mul(col_in[31:24], 4'he) ^ gf_mul(col_in[23:16], 4'hb)
			^ gf_mul(col_in[15:8], 4'hd) ^ gf_mul(col_in[7:0], 4'h9);
		col_res[23:16] = gf_mul(col_in[31:24], 4'h9) ^ gf_mul(col_in[23:16], 4'he)
			^ gf_mul(col_in[15:8], 4'hb) ^ gf_mul(col_in[7:0], 4'hd);
		col_res[15:8] = gf_mul(col_in[31:24], 4'hd) ^ gf_mul(col_in[23:16], 4'h9)
			^ gf_mul(col_in[15:8], 4'he) ^ gf_mul(col_in[7:0], 4'hb);
		col_res[7:0] = gf_mul(col_in[31:24], 4'hb) ^ gf_mul(col_in[23:16], 4'hd)
			^ gf_mul(col_in[15:8], 4'h9) ^ gf_mul(col_in[7:0], 4'he);
	end

	always_ff @(posedge CLK)
	begin
		if (RESET)
			col_reg <= '0;
		else if (mix_en)
			col_reg[(NUM_COLS - 1 - col) * 32 +: 32] <= col_res;
	end

	assign mix_out = col_reg;

endmodule

`default_nettype wire

// ==== src/aes_dec_state.sv ====
////////////////////
// AES decryption state register
// inverse shift rows, inverse sub bytes and add round key
////////////////////

`timescale 1ns/1ps
`default_nettype none

module aes_dec_state
	import aes_dec_pkg::*;
(
	input  logic       CLK,
	input  logic       RESET,
	input  logic       load,
	input  aes_op_t    op,
	input  aes_block_t msg_in,
	input  aes_block_t round_key,
	input  aes_block_t mix_out,
	output aes_block_t state
);

	aes_block_t shifted;
	aes_block_t subbed;

	// byte 4*c+r holds row r of column c, byte 0 at the top
	always_comb
	begin
		for (int c = 0; c < NUM_COLS; c++)
		begin
			for (int r = 0; r < 4; r++)
			begin
				// row r rotates right by r columns
				shifted[127 - 8 * (4 * c + r) -: 8] =
					state[127 - 8 * (4 * ((c - r + NUM_COLS) % NUM_COLS) + r) -: 8];
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < 16; i++)
			subbed[8 * i +: 8] = inv_sbox(state[8 * i +: 8]);
	end

	always_ff @(posedge CLK)
	begin
		if (RESET)
			state <= '0;
		else if (load)
			state <= msg_in;
		else
		begin
			case (op)
			op_add_key:
				state <= state ^ round_key;
			op_inv_shift:
				state <= shifted;
			op_inv_sub:
				state <= subbed;
			op_inv_mix:
				state <= mix_out;
			default:
				state <= state;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/aes_dec_top.sv ====
////////////////////
// AES-128 iterative decryption core
////////////////////

`timescale 1ns/1ps
`default_nettype none

module aes_dec_top
	import aes_dec_pkg::*;
(
	input  logic       CLK,
	input  logic       RESET,
	input  logic       start,
	input  aes_block_t key,
	input  aes_block_t msg_in,
	output logic       done,
	output aes_block_t msg_out
);

	logic load;
	logic key_step;
	logic mix_en;
	aes_round_t round;
	aes_op_t op;
	aes_col_t col;
	aes_block_t round_key;
	aes_block_t mix_out;
	aes_block_t state;

	aes_dec_ctrl ctrl0 (
		.CLK      (CLK),
		.RESET    (RESET),
		.start    (start),
		.done     (done),
		.load     (load),
		.key_step (key_step),
		.round    (round),
		.op       (op),
		.mix_en   (mix_en),
		.col      (col)
	);

	aes_key_expand key0 (
		.CLK       (CLK),
		.RESET     (RESET),
		.load      (load),
		.key_step  (key_step),
		.round     (round),
		.key       (key),
		.round_key (round_key)
	);

	aes_inv_mix_col mix0 (
		.CLK     (CLK),
		.RESET   (RESET),
		.mix_en  (mix_en),
		.col     (col),
		.state   (state),
		.mix_out (mix_out)
	);

	aes_dec_state state0 (
		.CLK       (CLK),
		.RESET     (RESET),
		.load      (load),
		.op        (op),
		.msg_in    (msg_in),
		.round_key (round_key),
		.mix_out   (mix_out),
		.state     (state)
	);

	assign msg_out = state;

endmodule

`default_nettype wire

// ==== tb/aes_dec_tb.sv ====
////////////////////
// AES-128 decryption core testbench
// directed FIPS-197 runs, done level and input latching
////////////////////

`timescale 1ns/1ps
`default_nettype none

module aes_dec_tb
	import aes_dec_pkg::*;
();

	localparam aes_block_t KEY_A = 128'h000102030405060708090a0b0c0d0e0f;
	localparam aes_block_t CT_A = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam aes_block_t PT_A = 128'h00112233445566778899aabbccddeeff;
	localparam aes_block_t KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam aes_block_t CT_B = 128'h3925841d02dc09fbdc118597196a0b32;
	localparam aes_block_t PT_B = 128'h3243f6a8885a308d313198a2e0370734;
	// start edge to done, from the phase counts
	localparam int DONE_LATENCY = 10 + 1 + 9 * 8 + 3 + 1;
	// start low is seen at the next edge, done drops one edge later
	localparam int DONE_FALL = 2;

	logic CLK;
	logic RESET;
	logic start;
	logic done;
	aes_block_t key;
	aes_block_t msg_in;
	aes_block_t msg_out;
	int errors;
	int checks;
	integer seed;

	aes_dec_top dut0 (
		.CLK     (CLK),
		.RESET   (RESET),
		.start   (start),
		.key     (key),
		.msg_in  (msg_in),
		.done    (done),
		.msg_out (msg_out)
	);

	initial
	begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic check_block(input string name, input aes_block_t got, input aes_block_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// counts falling edges until done is seen high
	task automatic wait_done(input int limit, output int cycles, output logic seen);
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < limit)
		begin
			@(negedge CLK);
			cycles++;
			seen = done;
		end
	endtask

	task automatic release_start(input int limit);
		int n;
		n = 0;
		@(negedge CLK);
		start = 1'b0;
		while (done && n < limit)
		begin
			@(negedge CLK);
			n++;
		end
		checks++;
		if (done)
		begin
			errors++;
			$display("done still high %0d cycles after start was dropped", n);
		end
		else if (n != DONE_FALL)
		begin
			errors++;
			$display("done fell %0d cycles after start was dropped, not %0d", n, DONE_FALL);
		end
	endtask

	task automatic idle_gap();
		int n;
		n = ($random(seed) & 3) + 1;
		repeat (n) @(negedge CLK);
	endtask

	// start is held high until done is seen
	task automatic run_block(input aes_block_t k, input aes_block_t ct, input aes_block_t pt,
		input logic scramble);
		int cycles;
		logic seen;
		@(negedge CLK);
		key = k;
		msg_in = ct;
		start = 1'b1;
		@(negedge CLK);
		if (scramble)
		begin
			key = {$random(seed), $random(seed), $random(seed), $random(seed)};
			msg_in = {$random(seed), $random(seed), $random(seed), $random(seed)};
		end
		wait_done(DONE_LATENCY + 50, cycles, seen);
		checks++;
		if (!seen)
		begin
			errors++;
			$display("timeout, done never rose after start");
		end
		else
		begin
			if (cycles != DONE_LATENCY)
			begin
				errors++;
				$display("done rose %0d cycles after start, not %0d", cycles, DONE_LATENCY);
			end
			check_block("msg_out", msg_out, pt);
		end
	endtask

	task automatic test_reset();
		repeat (8)
		begin
			@(negedge CLK);
			check_bit("done", done, 1'b0);
		end
	endtask

	task automatic test_vectors();
		run_block(KEY_A, CT_A, PT_A, 1'b0);
		release_start(4);
		idle_gap();
		// new key right after the first run
		run_block(KEY_B, CT_B, PT_B, 1'b0);
		release_start(4);
		idle_gap();
	endtask

	task automatic test_done_level();
		run_block(KEY_B, CT_B, PT_B, 1'b0);
		repeat (20)
		begin
			@(negedge CLK);
			check_bit("done", done, 1'b1);
			check_block("msg_out", msg_out, PT_B);
		end
		release_start(2);
		idle_gap();
	endtask

	task automatic test_input_latch();
		run_block(KEY_A, CT_A, PT_A, 1'b1);
		release_start(4);
		idle_gap();
	endtask

	initial
	begin
		errors = 0;
		checks = 0;
		seed = 32'h43a5_ee22;
		RESET = 1'b1;
		start = 1'b0;
		key = '0;
		msg_in = '0;
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b0;
		test_reset();
		test_vectors();
		test_done_level();
		test_input_latch();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/aes_dec_pkg.sv
src/aes_dec_ctrl.sv
src/aes_key_expand.sv
src/aes_inv_mix_col.sv
src/aes_dec_state.sv
src/aes_dec_top.sv
tb/aes_dec_tb.sv

// ==== Bender.yml ====
package:
  name: aes_dec

sources:
  - src/aes_dec_pkg.sv
  - src/aes_dec_ctrl.sv
  - src/aes_key_expand.sv
  - src/aes_inv_mix_col.sv
  - src/aes_dec_state.sv
  - src/aes_dec_top.sv
  - target: test
    files:
      - tb/aes_dec_tb.sv
